/* rtl/crc_consts.svh */
`ifndef CRC_CONSTS_SVH
`define CRC_CONSTS_SVH

// Bytes carried by one 128-bit beat
`define CRC_WORD_BYTES 16

// Ethernet CRC-32 generator, normal (MSB first) form
`define CRC_POLY 32'h04C11DB7

// Register value at the start of every frame
`define CRC_INIT 32'hFFFFFFFF

// Cycles from the cycle of a last beat to its result strobe
`define CRC_LATENCY 5

`endif

/* rtl/crc_types_pkg.sv */
`include "crc_consts.svh"

package crc_types_pkg;

	// One CRC-32 register value
	typedef logic [31:0] crc_t;

	// One beat of frame data
	// Byte 0, first on the wire, sits in the top byte
	typedef logic [`CRC_WORD_BYTES*8-1:0] data_word_t;

	// Valid bytes in a beat, 1 to 16
	typedef logic [4:0] byte_count_t;

	// Bytes left for the final tail step, 0 to 3
	typedef logic [1:0] tail_count_t;

endpackage

/* rtl/crc_stream_pkg.sv */
package crc_stream_pkg;

	//////////////////////////////////////////////////////////////////////
	// Input side

	// One data beat, no back-pressure
	// len must be 16 unless last is set
	typedef struct packed {
		logic valid;
		logic last;
		crc_types_pkg::byte_count_t len;
		crc_types_pkg::data_word_t data;
	} word_beat_t;

	//////////////////////////////////////////////////////////////////////
	// Output side

	// One-cycle result strobe per frame
	// fcs holds the wire bytes, first byte in bits 31:24
	typedef struct packed {
		logic valid;
		crc_types_pkg::crc_t fcs;
	} crc_result_t;

endpackage

/* rtl/crc32_step_comb.sv */
`timescale 1ns/100ps
`include "crc_consts.svh"

module crc32_step_comb #(
	parameter int NUM_BYTES = 16
) (
	input  logic [NUM_BYTES*8-1:0] d,
	input  crc_types_pkg::crc_t c,
	output crc_types_pkg::crc_t crc
);

	// Unrolled serial CRC over a fixed number of bytes
	// Byte 0 is in the top bits of d and goes in first
	// Inside a byte the LSB goes in first, as on the wire
	// Register is kept in normal bit order and not complemented
	always_comb begin
		crc_types_pkg::crc_t r;
		logic fb;

		r = c;
		for (int i = 0; i < NUM_BYTES; i++) begin
			for (int k = 0; k < 8; k++) begin
				// Feedback from the register MSB and the data bit
				fb = r[31] ^ d[(NUM_BYTES - 1 - i) * 8 + k];

				// Shift, then fold in the polynomial on feedback
				r = {r[30:0], 1'b0} ^ ({32{fb}} & `CRC_POLY);
			end
		end

		crc = r;
	end

endmodule

/* rtl/crc32_tail_comb.sv */
`timescale 1ns/100ps
`include "crc_consts.svh"

module crc32_tail_comb (
	input  logic [31:0] d,
	input  crc_types_pkg::tail_count_t len,
	input  crc_types_pkg::crc_t c,
	output crc_types_pkg::crc_t crc
);

	// Variable-length CRC step over the leading bytes of a 32-bit word
	// Only the first len bytes are folded in, so len 0 passes c through
	// Byte 0 sits in d[31:24]
	always_comb begin
		crc_types_pkg::crc_t r;
		logic fb;

		r = c;
		for (int i = 0; i < 4; i++) begin
			for (int k = 0; k < 8; k++) begin
				// LSB of each byte first
				fb = r[31] ^ d[24 - 8 * i + k];

				// Bytes past len leave the register alone
				if (i < int'(len)) begin
					r = {r[30:0], 1'b0} ^ ({32{fb}} & `CRC_POLY);
				end
			end
		end

		crc = r;
	end

endmodule

/* rtl/crc32_x128_pipe.sv */
`timescale 1ns/100ps
`include "crc_consts.svh"

module crc32_x128_pipe (
	input  logic clk,
	input  logic reset,
	input  crc_stream_pkg::word_beat_t beat,
	output crc_stream_pkg::crc_result_t result
);

	// Control part that every tail stage carries
	// done means crc_out already holds the final register
	typedef struct packed {
		logic valid;
		logic done;
		crc_types_pkg::crc_t crc_out;
	} stage_ctl_t;

	//////////////////////////////////////////////////////////////////////
	// Running CRC over full words

	crc_types_pkg::crc_t crc_run;
	logic first_beat;
	crc_types_pkg::crc_t crc_in;
	crc_types_pkg::crc_t crc_x128;
	logic last_in;

	// A frame's first beat starts over from the init value
	assign crc_in = first_beat ? `CRC_INIT : crc_run;
	assign last_in = beat.valid && beat.last;

	crc32_step_comb #(.NUM_BYTES(`CRC_WORD_BYTES)) step_x128_i (
		.d(beat.data),
		.c(crc_in),
		.crc(crc_x128)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			crc_run <= `CRC_INIT;
			first_beat <= 1'b1;
		end else if (beat.valid) begin
			crc_run <= crc_x128;
			// Any last beat arms a restart for the next frame
			first_beat <= beat.last;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tail pipeline registers

	stage_ctl_t s0_ctl;
	stage_ctl_t s1_ctl;
	stage_ctl_t s2_ctl;
	stage_ctl_t s3_ctl;
	crc_types_pkg::data_word_t s0_data;
	crc_types_pkg::data_word_t s1_data;
	logic [63:0] s2_data;
	logic [31:0] s3_data;
	crc_types_pkg::crc_t s0_crc_in;
	crc_types_pkg::crc_t s1_crc_in;
	crc_types_pkg::crc_t s2_crc_in;
	crc_types_pkg::crc_t s3_crc_in;
	crc_types_pkg::byte_count_t s0_len;
	crc_types_pkg::byte_count_t s1_len;
	logic [2:0] s2_len;
	crc_types_pkg::tail_count_t s3_len;
	crc_types_pkg::crc_t crc_x64;
	crc_types_pkg::crc_t s1_crc_x64;
	crc_types_pkg::crc_t crc_x32;
	crc_types_pkg::crc_t crc_tail;
	logic out_valid;
	crc_types_pkg::crc_t out_crc;
	crc_types_pkg::crc_t out_not;

	// Upper half of the last word, from the CRC before that word
	crc32_step_comb #(.NUM_BYTES(8)) step_x64_i (
		.d(s0_data[127:64]),
		.c(s0_crc_in),
		.crc(crc_x64)
	);

	// Next 4 bytes of whatever stage 2 kept
	crc32_step_comb #(.NUM_BYTES(4)) step_x32_i (
		.d(s2_data[63:32]),
		.c(s2_crc_in),
		.crc(crc_x32)
	);

	// Last 0 to 3 bytes
	crc32_tail_comb tail_i (
		.d(s3_data),
		.len(s3_len),
		.c(s3_crc_in),
		.crc(crc_tail)
	);

	always_ff @(posedge clk) begin
		// Stage 0, only last beats need the tail path
		s0_ctl.valid <= last_in;
		s0_ctl.done <= beat.last && (beat.len == `CRC_WORD_BYTES);
		s0_ctl.crc_out <= crc_x128;
		s0_data <= beat.data;
		s0_crc_in <= crc_in;
		s0_len <= beat.len;

		// Stage 1, register the 64-bit update
		s1_ctl <= s0_ctl;
		s1_data <= s0_data;
		s1_crc_in <= s0_crc_in;
		s1_len <= s0_len;
		s1_crc_x64 <= crc_x64;

		// Stage 2, keep the x64 result when 8 or more bytes remain
		s2_ctl.valid <= s1_ctl.valid;
		s2_len <= s1_len[2:0];
		if (!s1_ctl.done && s1_len == 5'd8) begin
			s2_ctl.done <= 1'b1;
			s2_ctl.crc_out <= s1_crc_x64;
		end else begin
			s2_ctl.done <= s1_ctl.done;
			s2_ctl.crc_out <= s1_ctl.crc_out;
		end
		if (s1_len[3]) begin
			s2_data <= s1_data[63:0];
			s2_crc_in <= s1_crc_x64;
		end else begin
			s2_data <= s1_data[127:64];
			s2_crc_in <= s1_crc_in;
		end

		// Stage 3, same again for 4 bytes
		s3_ctl.valid <= s2_ctl.valid;
		s3_len <= s2_len[1:0];
		if (!s2_ctl.done && s2_len == 3'd4) begin
			s3_ctl.done <= 1'b1;
			s3_ctl.crc_out <= crc_x32;
		end else begin
			s3_ctl.done <= s2_ctl.done;
			s3_ctl.crc_out <= s2_ctl.crc_out;
		end
		if (s2_len[2]) begin
			s3_data <= s2_data[31:0];
			s3_crc_in <= crc_x32;
		end else begin
			s3_data <= s2_data[63:32];
			s3_crc_in <= s2_crc_in;
		end

		// Output stage, byte tail unless already finished
		out_valid <= s3_ctl.valid;
		out_crc <= s3_ctl.done ? s3_ctl.crc_out : crc_tail;

		// Flush every stage
		if (reset) begin
			s0_ctl.valid <= 1'b0;
			s1_ctl.valid <= 1'b0;
			s2_ctl.valid <= 1'b0;
			s3_ctl.valid <= 1'b0;
			out_valid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result, complemented and bit-reversed per byte into wire order

	assign out_not = ~out_crc;

	always_comb begin
		result.valid = out_valid;
		for (int i = 0; i < 4; i++) begin
			for (int k = 0; k < 8; k++) begin
				result.fcs[i * 8 + k] = out_not[i * 8 + 7 - k];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	a_len_range: assert property (@(posedge clk) disable iff (reset)
		beat.valid |-> (beat.len >= 5'd1 && beat.len <= `CRC_WORD_BYTES))
		else $error("beat len out of range");

	a_len_full: assert property (@(posedge clk) disable iff (reset)
		(beat.valid && !beat.last) |-> (beat.len == `CRC_WORD_BYTES))
		else $error("partial beat that is not last");

	// Back-to-back results need back-to-back last beats
	a_result_spacing: assert property (@(posedge clk) disable iff (reset)
		(result.valid && $past(result.valid)) |->
			($past(last_in, `CRC_LATENCY) && $past(last_in, `CRC_LATENCY + 1)))
		else $error("result strobes closer than their last beats");

endmodule

/* rtl/crc_frame_engine.sv */
`timescale 1ns/100ps

module crc_frame_engine (
	input  logic clk,
	input  logic reset,
	input  crc_stream_pkg::word_beat_t beat,
	output crc_stream_pkg::crc_result_t result
);

	//////////////////////////////////////////////////////////////////////
	// Frame check sequence engine

	// Beats go straight into the pipeline, no buffering
	// One result strobe per frame, fixed latency after the last beat
	// Back-to-back frames share the pipeline without a gap
	crc32_x128_pipe pipe_i (
		.clk(clk),
		.reset(reset),
		.beat(beat),
		.result(result)
	);

endmodule

/* tests/crc_ref_model.svh */
`ifndef CRC_REF_MODEL_SVH
`define CRC_REF_MODEL_SVH

// Frame bytes in wire order, and the beats cut from them
typedef logic [7:0] byte_queue_t[$];
typedef crc_stream_pkg::word_beat_t beat_queue_t[$];

// Bitwise Ethernet FCS in reflected form
// Register shifts right, so the generator is mirrored first
// Result comes back in wire order, first FCS byte in bits 31:24
function automatic crc_types_pkg::crc_t ref_fcs(input byte_queue_t bytes);
	logic [31:0] poly;
	logic [31:0] poly_r;
	logic [31:0] r;

	poly = `CRC_POLY;
	for (int k = 0; k < 32; k++) begin
		poly_r[k] = poly[31 - k];
	end

	r = `CRC_INIT;
	foreach (bytes[i]) begin
		r = r ^ {24'h0, bytes[i]};
		for (int k = 0; k < 8; k++) begin
			r = r[0] ? ((r >> 1) ^ poly_r) : (r >> 1);
		end
	end

	// Complement, then the low byte goes out first
	r = ~r;
	return {r[7:0], r[15:8], r[23:16], r[31:24]};
endfunction

// Cut a frame into 16-byte beats, byte 0 in the top bits
// Unused bytes of the last beat get random filler
task automatic cut_into_beats(input byte_queue_t bytes, output beat_queue_t beats);
	crc_stream_pkg::word_beat_t b;
	int n;
	int pos;

	beats = {};
	pos = 0;
	while (pos < bytes.size()) begin
		n = bytes.size() - pos;
		if (n > `CRC_WORD_BYTES) begin
			n = `CRC_WORD_BYTES;
		end
		b.valid = 1'b1;
		b.last = (pos + n == bytes.size());
		b.len = 5'(n);
		for (int i = 0; i < `CRC_WORD_BYTES; i++) begin
			b.data[127 - 8 * i -: 8] = (i < n) ? bytes[pos + i] : 8'($urandom);
		end
		beats.push_back(b);
		pos += n;
	end
endtask

`endif

/* tests/tb_crc_frame_engine.sv */
`timescale 1ns/100ps
`include "crc_consts.svh"

module tb_crc_frame_engine;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 2;
	localparam int GAP_FRAMES = 4;
	localparam int MAX_GAP = 3;
	// Beats and idle cycles of the tests, frame by frame
	localparam int TEST_CYCLES = 1 + 96 + 48 + 14 + GAP_FRAMES * 4 * (MAX_GAP + 1) + 3;
	// Drains, the reset test and slack
	localparam int MARGIN_CYCLES = 200;

	// What one frame should give, and when
	typedef struct packed {
		int unsigned due;
		crc_types_pkg::crc_t fcs;
	} expect_t;

	logic clk;
	logic reset;
	crc_stream_pkg::word_beat_t beat;
	crc_stream_pkg::crc_result_t result;

	int unsigned cycle_count = 0;
	expect_t expected[$];
	int value_errors = 0;
	int other_errors = 0;
	int frames_sent = 0;
	int results_seen = 0;

	`include "crc_ref_model.svh"

	crc_frame_engine crc_frame_engine_i (
		.clk(clk),
		.reset(reset),
		.beat(beat),
		.result(result)
	);

	//////////////////////////////////////////////////////////////////////
	// Clock, cycle count, watchdog

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		#(PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES));
		$display("Timeout: the run did not finish in %0d cycles", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Result monitor sampled mid-cycle where outputs are stable

	task automatic check_result();
		expect_t e;

		// Anything overdue never showed up
		while (expected.size() != 0 && expected[0].due < cycle_count) begin
			e = expected.pop_front();
			other_errors++;
			$display("Missing result: frame due in cycle %0d gave nothing by %0t", e.due, $time);
		end
		if (result.valid) begin
			results_seen++;
			if (expected.size() == 0) begin
				other_errors++;
				$display("Unexpected result at %0t: no frame was waiting for one", $time);
			end else begin
				e = expected.pop_front();
				assert (e.due == cycle_count) else begin
					value_errors++;
					$display("CHECK FAILED at %0t: result in cycle %0d, expected cycle %0d",
						$time, cycle_count, e.due);
				end
				assert (result.fcs == e.fcs) else begin
					value_errors++;
					$display("CHECK FAILED at %0t: fcs %h, expected %h",
						$time, result.fcs, e.fcs);
				end
			end
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			check_result();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers that all drive on the falling edge

	function automatic byte_queue_t random_bytes(input int len);
		byte_queue_t q;

		for (int i = 0; i < len; i++) begin
			q.push_back(8'($urandom));
		end
		return q;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			beat = '0;
		end
	endtask

	// Optional random gap before each beat
	// The last beat books its result LATENCY cycles ahead
	task automatic drive_frame(input byte_queue_t bytes, input int max_gap,
		input crc_types_pkg::crc_t fcs_exp);
		beat_queue_t beats;
		expect_t e;

		cut_into_beats(bytes, beats);
		foreach (beats[i]) begin
			if (max_gap > 0) begin
				idle_cycles($urandom_range(max_gap, 0));
			end
			@(negedge clk);
			beat = beats[i];
			if (beats[i].last) begin
				e.due = cycle_count + `CRC_LATENCY;
				e.fcs = fcs_exp;
				expected.push_back(e);
				frames_sent++;
			end
		end
	endtask

	// Idle input until the monitor has seen every booked result
	task automatic wait_results();
		@(negedge clk);
		beat = '0;
		while (expected.size() != 0) begin
			@(negedge clk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	// Standard check string with its known FCS
	task automatic check_known_string();
		byte_queue_t msg;

		for (int i = 0; i < 9; i++) begin
			msg.push_back(8'h31 + 8'(i));
		end
		assert (ref_fcs(msg) == 32'h2639F4CB) else begin
			value_errors++;
			$display("CHECK FAILED at %0t: model gives %h for the check string",
				$time, ref_fcs(msg));
		end
		drive_frame(msg, 0, 32'h2639F4CB);
		wait_results();
	endtask

	// Every length up to three words hits each tail path
	task automatic sweep_frame_lengths();
		byte_queue_t bytes;

		for (int len = 1; len <= 48; len++) begin
			bytes = random_bytes(len);
			drive_frame(bytes, 0, ref_fcs(bytes));
			idle_cycles(1);
		end
		wait_results();
	endtask

	// First three frames are one beat each, so results come back to back
	task automatic send_back_to_back();
		int lens[8];
		byte_queue_t bytes;

		lens = '{3, 16, 9, 40, 17, 1, 33, 24};
		foreach (lens[i]) begin
			bytes = random_bytes(lens[i]);
			drive_frame(bytes, 0, ref_fcs(bytes));
		end
		wait_results();
	endtask

	task automatic insert_idle_gaps();
		byte_queue_t bytes;

		for (int f = 0; f < GAP_FRAMES; f++) begin
			bytes = random_bytes($urandom_range(64, 17));
			drive_frame(bytes, MAX_GAP, ref_fcs(bytes));
		end
		wait_results();
	endtask

	// One whole frame, then the opening beat of another, then reset
	// Reset hits while the whole frame is still in the tail stages
	// The frame after reset only matches if the running CRC starts over
	task automatic reset_mid_frame();
		byte_queue_t bytes;
		beat_queue_t beats;

		bytes = random_bytes(40);
		cut_into_beats(bytes, beats);
		foreach (beats[i]) begin
			@(negedge clk);
			beat = beats[i];
		end
		// Opening beat of a frame that never gets its last beat
		@(negedge clk);
		beat = beats[0];
		@(negedge clk);
		beat = '0;
		reset = 1'b1;
		idle_cycles(RESET_CYCLES);
		reset = 1'b0;
		// Any stray result is caught by the monitor
		idle_cycles(`CRC_LATENCY + 2);
		bytes = random_bytes(20);
		drive_frame(bytes, 0, ref_fcs(bytes));
		wait_results();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and closing report

	initial begin
		void'($urandom(97219));
		reset = 1'b1;
		beat = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		check_known_string();
		sweep_frame_lengths();
		send_back_to_back();
		insert_idle_gaps();
		reset_mid_frame();

		if (results_seen != frames_sent) begin
			other_errors++;
			$display("Result count off: %0d frames sent, %0d results seen",
				frames_sent, results_seen);
		end
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+rtl
+incdir+tests
rtl/crc_types_pkg.sv
rtl/crc_stream_pkg.sv
rtl/crc32_step_comb.sv
rtl/crc32_tail_comb.sv
rtl/crc32_x128_pipe.sv
rtl/crc_frame_engine.sv
tests/tb_crc_frame_engine.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CRC frame engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_crc_frame_engine
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0
